/* hdl/syscon_defs.svh */
// bus sizing macros for the wishbone system controller, included by the package and rtl.
`ifndef SYSCON_DEFS_SVH
`define SYSCON_DEFS_SVH

// master 0 is the priority master, 1 to 3 share the bus round-robin.
`define SYSCON_N_MASTERS 4

// slave 0 takes every cycle that no select line claims.
`define SYSCON_N_SLAVES 4

// word address, byte address bits 31 to 2.
`define SYSCON_ADR_W 30

`define SYSCON_DAT_W 32

`define SYSCON_SEL_W 4

`endif

/* hdl/syscon_pkg.sv */
// shared types of the wishbone system controller, imported by every rtl block.
`default_nettype none

`include "syscon_defs.svh"

package syscon_pkg;

    // current owner of the shared bus.
    typedef enum logic [2:0] {
        GNT_NONE = 3'd0,
        GNT_P    = 3'd1,
        GNT_R1   = 3'd2,
        GNT_R2   = 3'd3,
        GNT_R3   = 3'd4
    } grant_t;

    typedef logic [`SYSCON_ADR_W-1:0] adr_t;
    typedef logic [`SYSCON_DAT_W-1:0] dat_t;
    typedef logic [`SYSCON_SEL_W-1:0] sel_t;

endpackage

`default_nettype wire

/* hdl/wb_bus_if.sv */
// shared wishbone cycle between the master mux and the slave router, one per controller.
`timescale 1ns/1ps
`default_nettype none

`include "syscon_defs.svh"

interface wb_bus_if
    import syscon_pkg::*;
();

    // request side, from the granted master.
    logic cyc_stb;
    logic we;
    adr_t adr;
    sel_t sel;
    dat_t wdat;

    // response side, from the routed slave.
    logic ack;
    logic rty;
    logic err;
    dat_t rdat;

    modport master (output cyc_stb, we, adr, sel, wdat, input ack, rty, err, rdat);

    modport slave (input cyc_stb, output ack, rty, err, rdat);

endinterface

`default_nettype wire

/* hdl/grant_arbiter.sv */
// bus grant register of the system controller, priority master first then round-robin.
`timescale 1ns/1ps
`default_nettype none

`include "syscon_defs.svh"

module grant_arbiter
    import syscon_pkg::*;
(
    input  wire                          CLK_I,
    input  wire                          reset_n,
    input  wire                          halt_i,
    input  wire [`SYSCON_N_MASTERS-1:0] req_i,
    output grant_t                       grant_o,
    output logic                         busy_o
);

    grant_t grant_q;
    grant_t grant_d;

    // search order starts after the last round-robin owner.
    function automatic grant_t rr_next(input logic [3:1] rr_req, input grant_t cur);
        grant_t pick;
        pick = cur;
        case (cur)
            GNT_R1: begin
                if (rr_req[2])      pick = GNT_R2;
                else if (rr_req[3]) pick = GNT_R3;
                else if (rr_req[1]) pick = GNT_R1;
            end
            GNT_R2: begin
                if (rr_req[3])      pick = GNT_R3;
                else if (rr_req[1]) pick = GNT_R1;
                else if (rr_req[2]) pick = GNT_R2;
            end
            default: begin
                if (rr_req[1])      pick = GNT_R1;
                else if (rr_req[2]) pick = GNT_R2;
                else if (rr_req[3]) pick = GNT_R3;
            end
        endcase
        return pick;
    endfunction

    // owner still in its cycle.
    always_comb begin
        case (grant_q)
            GNT_P:   busy_o = req_i[0];
            GNT_R1:  busy_o = req_i[1];
            GNT_R2:  busy_o = req_i[2];
            GNT_R3:  busy_o = req_i[3];
            default: busy_o = 1'b0;
        endcase
    end

    always_comb begin
        grant_d = grant_q;
        if (!busy_o) begin
            if (halt_i)        grant_d = GNT_NONE;
            else if (req_i[0]) grant_d = GNT_P;
            else               grant_d = rr_next(req_i[3:1], grant_q);
        end
    end

    always_ff @(posedge CLK_I or negedge reset_n) begin
        if (!reset_n) begin
            grant_q <= GNT_NONE;
        end else begin
            grant_q <= grant_d;
        end
    end

    assign grant_o = grant_q;

endmodule

`default_nettype wire

/* hdl/master_mux.sv */
// steers the granted master onto the shared bus and hands responses back to it.
`timescale 1ns/1ps
`default_nettype none

`include "syscon_defs.svh"

module master_mux
    import syscon_pkg::*;
(
    input  grant_t                        grant_i,
    input  wire                           busy_i,
    input  wire  [`SYSCON_N_MASTERS-1:0] m_we_i,
    input  adr_t                          m_adr_i [`SYSCON_N_MASTERS],
    input  sel_t                          m_sel_i [`SYSCON_N_MASTERS],
    input  dat_t                          m_dat_i [`SYSCON_N_MASTERS],
    output logic [`SYSCON_N_MASTERS-1:0] m_ack_o,
    output logic [`SYSCON_N_MASTERS-1:0] m_rty_o,
    output logic [`SYSCON_N_MASTERS-1:0] m_err_o,
    output adr_t                          adr_early_o,
    input  adr_t                          adr_and_mask_i,
    input  adr_t                          adr_or_mask_i,
    wb_bus_if.master                      bus
);

    logic [1:0] gnt_idx;
    logic       gnt_valid;

    always_comb begin
        gnt_idx   = 2'd0;
        gnt_valid = 1'b1;
        case (grant_i)
            GNT_P:   gnt_idx = 2'd0;
            GNT_R1:  gnt_idx = 2'd1;
            GNT_R2:  gnt_idx = 2'd2;
            GNT_R3:  gnt_idx = 2'd3;
            default: gnt_valid = 1'b0;
        endcase
    end

    // request fields, zero while nobody owns the bus.
    assign adr_early_o = gnt_valid ? m_adr_i[gnt_idx] : '0;
    assign bus.we      = gnt_valid & m_we_i[gnt_idx];
    assign bus.sel     = gnt_valid ? m_sel_i[gnt_idx] : '0;
    assign bus.wdat    = gnt_valid ? m_dat_i[gnt_idx] : '0;
    assign bus.cyc_stb = busy_i;

    assign bus.adr = (adr_early_o & adr_and_mask_i) | adr_or_mask_i;

    // responses go to the owner only.
    always_comb begin
        m_ack_o = '0;
        m_rty_o = '0;
        m_err_o = '0;
        if (gnt_valid) begin
            m_ack_o[gnt_idx] = bus.ack;
            m_rty_o[gnt_idx] = bus.rty;
            m_err_o[gnt_idx] = bus.err;
        end
    end

endmodule

`default_nettype wire

/* hdl/slave_router.sv */
// routes the shared cycle to one slave and muxes that slave's response onto the bus.
`timescale 1ns/1ps
`default_nettype none

`include "syscon_defs.svh"

module slave_router
    import syscon_pkg::*;
(
    input  wire  [`SYSCON_N_SLAVES-1:1] slave_sel_i,
    output logic [`SYSCON_N_SLAVES-1:0] s_cyc_o,
    output logic [`SYSCON_N_SLAVES-1:0] s_stb_o,
    input  wire  [`SYSCON_N_SLAVES-1:0] s_ack_i,
    input  wire  [`SYSCON_N_SLAVES-1:0] s_rty_i,
    input  wire  [`SYSCON_N_SLAVES-1:0] s_err_i,
    input  dat_t                         s_dat_i [`SYSCON_N_SLAVES],
    wb_bus_if.slave                      bus
);

    logic [1:0] slv_idx;

    // lowest selected index wins, slave 0 when none is selected.
    always_comb begin
        slv_idx = 2'd0;
        for (int i = `SYSCON_N_SLAVES - 1; i >= 1; i--) begin
            if (slave_sel_i[i]) begin
                slv_idx = i[1:0];
            end
        end
    end

    always_comb begin
        s_cyc_o          = '0;
        s_cyc_o[slv_idx] = bus.cyc_stb;
    end

    assign s_stb_o = s_cyc_o;

    // responses only count inside a cycle.
    assign bus.ack  = bus.cyc_stb & s_ack_i[slv_idx];
    assign bus.rty  = bus.cyc_stb & s_rty_i[slv_idx];
    assign bus.err  = bus.cyc_stb & s_err_i[slv_idx];
    assign bus.rdat = s_dat_i[slv_idx];

endmodule

`default_nettype wire

/* hdl/wb_syscon.sv */
// top of the wishbone system controller, four masters onto four slaves.
`timescale 1ns/1ps
`default_nettype none

`include "syscon_defs.svh"

module wb_syscon
    import syscon_pkg::*;
(
    input  wire                          CLK_I,
    input  wire                          reset_n,
    input  wire                          halt_i,

    input  wire  [`SYSCON_N_MASTERS-1:0] m_cyc_i,
    input  wire  [`SYSCON_N_MASTERS-1:0] m_stb_i,
    input  wire  [`SYSCON_N_MASTERS-1:0] m_we_i,
    input  adr_t                          m_adr_i [`SYSCON_N_MASTERS],
    input  sel_t                          m_sel_i [`SYSCON_N_MASTERS],
    input  dat_t                          m_dat_i [`SYSCON_N_MASTERS],
    output logic [`SYSCON_N_MASTERS-1:0] m_ack_o,
    output logic [`SYSCON_N_MASTERS-1:0] m_rty_o,
    output logic [`SYSCON_N_MASTERS-1:0] m_err_o,

    output adr_t                          bus_adr_o,
    output logic                          bus_we_o,
    output sel_t                          bus_sel_o,
    output dat_t                          bus_wdat_o,
    output dat_t                          bus_rdat_o,

    output adr_t                          adr_early_o,
    input  adr_t                          adr_and_mask_i,
    input  adr_t                          adr_or_mask_i,

    input  wire  [`SYSCON_N_SLAVES-1:1]  slave_sel_i,
    output logic [`SYSCON_N_SLAVES-1:0]  s_cyc_o,
    output logic [`SYSCON_N_SLAVES-1:0]  s_stb_o,
    input  wire  [`SYSCON_N_SLAVES-1:0]  s_ack_i,
    input  wire  [`SYSCON_N_SLAVES-1:0]  s_rty_i,
    input  wire  [`SYSCON_N_SLAVES-1:0]  s_err_i,
    input  dat_t                          s_dat_i [`SYSCON_N_SLAVES]
);

    logic [`SYSCON_N_MASTERS-1:0] req;
    grant_t                       grant;
    logic                         busy;

    wb_bus_if u_bus ();

    // a master requests with both cyc and stb.
    assign req = m_cyc_i & m_stb_i;

    grant_arbiter u_arb (
        .CLK_I   (CLK_I),
        .reset_n (reset_n),
        .halt_i  (halt_i),
        .req_i   (req),
        .grant_o (grant),
        .busy_o  (busy)
    );

    master_mux u_mux (
        .grant_i        (grant),
        .busy_i         (busy),
        .m_we_i         (m_we_i),
        .m_adr_i        (m_adr_i),
        .m_sel_i        (m_sel_i),
        .m_dat_i        (m_dat_i),
        .m_ack_o        (m_ack_o),
        .m_rty_o        (m_rty_o),
        .m_err_o        (m_err_o),
        .adr_early_o    (adr_early_o),
        .adr_and_mask_i (adr_and_mask_i),
        .adr_or_mask_i  (adr_or_mask_i),
        .bus            (u_bus.master)
    );

    slave_router u_router (
        .slave_sel_i (slave_sel_i),
        .s_cyc_o     (s_cyc_o),
        .s_stb_o     (s_stb_o),
        .s_ack_i     (s_ack_i),
        .s_rty_i     (s_rty_i),
        .s_err_i     (s_err_i),
        .s_dat_i     (s_dat_i),
        .bus         (u_bus.slave)
    );

    // common bus fields for the slaves.
    assign bus_adr_o  = u_bus.adr;
    assign bus_we_o   = u_bus.we;
    assign bus_sel_o  = u_bus.sel;
    assign bus_wdat_o = u_bus.wdat;
    assign bus_rdat_o = u_bus.rdat;

endmodule

`default_nettype wire

/* tb/wb_syscon_assertions.sv */
// bus protocol assertions for the system controller, bound into the top level by the bind below.
`timescale 1ns/1ps
`default_nettype none

`include "syscon_defs.svh"

module wb_syscon_assertions
    import syscon_pkg::*;
(
    input wire                          CLK_I,
    input wire                          reset_n,
    input wire  [`SYSCON_N_SLAVES-1:0]  s_cyc_o,
    input wire  [`SYSCON_N_SLAVES-1:0]  s_stb_o,
    input wire  [`SYSCON_N_MASTERS-1:0] m_ack_o,
    input wire  [`SYSCON_N_MASTERS-1:0] m_rty_o,
    input wire  [`SYSCON_N_MASTERS-1:0] m_err_o,
    input grant_t                       grant,
    input wire                          busy
);

    logic [`SYSCON_N_MASTERS-1:0] owner;

    always_comb begin
        case (grant)
            GNT_P:   owner = 4'b0001;
            GNT_R1:  owner = 4'b0010;
            GNT_R2:  owner = 4'b0100;
            GNT_R3:  owner = 4'b1000;
            default: owner = 4'b0000;
        endcase
    end

    a_one_slave: assert property (@(posedge CLK_I) disable iff (!reset_n) $onehot0(s_cyc_o))
        else $error("more than one slave cycle active");

    // a slave cycle is open exactly while the owner is busy.
    a_cyc_stb: assert property (@(posedge CLK_I) disable iff (!reset_n)
        (s_cyc_o == s_stb_o) && ((|s_cyc_o) == busy))
        else $error("slave cyc and stb do not follow the bus owner");

    // responses only to the owner.
    a_owner_resp: assert property (@(posedge CLK_I) disable iff (!reset_n)
        ((m_ack_o | m_rty_o | m_err_o) & ~owner) == '0)
        else $error("master response without grant");

    a_grant_hold: assert property (@(posedge CLK_I) disable iff (!reset_n) busy |=> $stable(grant))
        else $error("grant moved during a busy cycle");

endmodule

bind wb_syscon wb_syscon_assertions u_assertions (
    .CLK_I   (CLK_I),
    .reset_n (reset_n),
    .s_cyc_o (s_cyc_o),
    .s_stb_o (s_stb_o),
    .m_ack_o (m_ack_o),
    .m_rty_o (m_rty_o),
    .m_err_o (m_err_o),
    .grant   (grant),
    .busy    (busy)
);

`default_nettype wire

/* tb/tb_wb_syscon.sv */
// table-driven testbench for the system controller, with a slave responder model; run as top.
`timescale 1ns/1ps
`default_nettype none

`include "syscon_defs.svh"

module tb_wb_syscon
    import syscon_pkg::*;
();

    typedef struct packed {
        logic            halt;
        logic [3:0]      req;
        logic [3:1]      sel;
        logic [1:0]      kind;
        adr_t            and_m;
        adr_t            or_m;
        logic [2:0]      n;
        logic [3:0][1:0] order;
        logic [1:0]      slave;
    } row_t;

    logic       CLK_I;
    logic       reset_n;
    logic       halt_i;
    logic [3:0] m_cyc, m_stb, m_we, m_ack_o, m_rty_o, m_err_o;
    adr_t       m_adr [4];
    sel_t       m_sel [4];
    dat_t       m_dat [4];
    adr_t       bus_adr_o, adr_early_o, and_mask, or_mask;
    logic       bus_we_o;
    sel_t       bus_sel_o;
    dat_t       bus_wdat_o, bus_rdat_o;
    logic [3:1] slave_sel;
    logic [3:0] s_cyc_o, s_stb_o, s_ack, s_rty, s_err;
    dat_t       s_dat [4];

    integer      seed;
    int          errors;
    int          failed_rows;
    bit          timed_out;
    logic [31:0] row_const;
    row_t        rows[$];

    wb_syscon u_dut (
        .CLK_I (CLK_I), .reset_n (reset_n), .halt_i (halt_i),
        .m_cyc_i (m_cyc), .m_stb_i (m_stb), .m_we_i (m_we),
        .m_adr_i (m_adr), .m_sel_i (m_sel), .m_dat_i (m_dat),
        .m_ack_o (m_ack_o), .m_rty_o (m_rty_o), .m_err_o (m_err_o),
        .bus_adr_o (bus_adr_o), .bus_we_o (bus_we_o), .bus_sel_o (bus_sel_o),
        .bus_wdat_o (bus_wdat_o), .bus_rdat_o (bus_rdat_o), .adr_early_o (adr_early_o),
        .adr_and_mask_i (and_mask), .adr_or_mask_i (or_mask), .slave_sel_i (slave_sel),
        .s_cyc_o (s_cyc_o), .s_stb_o (s_stb_o), .s_ack_i (s_ack), .s_rty_i (s_rty),
        .s_err_i (s_err), .s_dat_i (s_dat)
    );

    initial begin
        CLK_I = 1'b0;
        forever #10 CLK_I = ~CLK_I;
    end

    task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic add_row(input logic h, input logic [3:0] req, input logic [3:1] sel,
                           input logic [1:0] kind, input adr_t and_m, input adr_t or_m,
                           input logic [2:0] n, input logic [7:0] order, input logic [1:0] slv);
        row_t r;
        r = {h, req, sel, kind, and_m, or_m, n, order, slv};
        rows.push_back(r);
    endtask

    // kind 0 is ack, 1 is rty, 2 is err.
    task automatic serve_one(input row_t row, input int m);
        bit ok;
        ok = 1'b0;
        for (int n = 0; n < 50 && !ok; n++) begin
            @(negedge CLK_I);
            ok = |s_cyc_o;
        end
        if (!ok) begin
            $display("timeout: no slave cycle started for master %0d", m);
            timed_out = 1'b1;
            return;
        end
        check("slave cyc", s_cyc_o, 32'd1 << row.slave);
        check("slave stb", s_stb_o, 32'd1 << row.slave);
        check("early adr", adr_early_o, m_adr[m]);
        check("bus adr", bus_adr_o, (m_adr[m] & row.and_m) | row.or_m);
        check("bus we", bus_we_o, m_we[m]);
        check("bus sel", bus_sel_o, m_sel[m]);
        check("bus wdat", bus_wdat_o, m_dat[m]);
        // slave model answers on this falling edge.
        s_ack[row.slave] = (row.kind == 2'd0);
        s_rty[row.slave] = (row.kind == 2'd1);
        s_err[row.slave] = (row.kind == 2'd2);
        ok = 1'b0;
        for (int n = 0; n < 50 && !ok; n++) begin
            @(negedge CLK_I);
            ok = |(m_ack_o | m_rty_o | m_err_o);
        end
        if (!ok) begin
            $display("timeout: master %0d never saw a response", m);
            timed_out = 1'b1;
            return;
        end
        check("master ack", m_ack_o, (row.kind == 2'd0) ? 32'd1 << m : 32'd0);
        check("master rty", m_rty_o, (row.kind == 2'd1) ? 32'd1 << m : 32'd0);
        check("master err", m_err_o, (row.kind == 2'd2) ? 32'd1 << m : 32'd0);
        check("read data", bus_rdat_o, row_const + row.slave);
        m_cyc[m] = 1'b0;
        m_stb[m] = 1'b0;
        s_ack = '0;
        s_rty = '0;
        s_err = '0;
    endtask

    task automatic apply_row(input int idx, input row_t row);
        int          errs_before;
        logic [31:0] r;
        errs_before = errors;
        row_const = $random(seed);
        for (int m = 0; m < 4; m++) begin
            r = $random(seed);
            m_adr[m] = r[29:0];
            m_dat[m] = $random(seed);
            m_sel[m] = r[31:28];
            s_dat[m] = row_const + m;
        end
        r = $random(seed);
        m_we = r[3:0];
        and_mask = row.and_m;
        or_mask = row.or_m;
        slave_sel = row.sel;
        halt_i = row.halt;
        m_cyc = row.req;
        m_stb = row.req;
        if (row.halt) begin
            repeat (10) begin
                @(negedge CLK_I);
                check("slave cyc under halt", s_cyc_o, 32'd0);
            end
            halt_i = 1'b0;
        end
        for (int k = 0; k < row.n && !timed_out; k++) begin
            serve_one(row, row.order[k]);
        end
        if (errors != errs_before || timed_out) begin
            failed_rows++;
            $display("row %0d: failed", idx);
        end else begin
            $display("row %0d: ok", idx);
        end
    endtask

    initial begin
        seed = 32'hb112;
        errors = 0;
        failed_rows = 0;
        timed_out = 1'b0;
        reset_n = 1'b0;
        halt_i = 1'b0;
        // every master requests and every slave answers while reset is held.
        m_cyc = '1;
        m_stb = '1;
        m_we = '0;
        and_mask = '1;
        or_mask = '0;
        slave_sel = '0;
        s_ack = '1;
        s_rty = '1;
        s_err = '1;
        for (int i = 0; i < 4; i++) begin
            m_adr[i] = '0;
            m_sel[i] = '0;
            m_dat[i] = '0;
            s_dat[i] = '0;
        end
        repeat (3) @(negedge CLK_I);
        check("slave cyc in reset", s_cyc_o, 32'd0);
        check("responses in reset", m_ack_o | m_rty_o | m_err_o, 32'd0);
        m_cyc = '0;
        m_stb = '0;
        s_ack = '0;
        s_rty = '0;
        s_err = '0;
        reset_n = 1'b1;
        @(negedge CLK_I);
        check("slave cyc after reset", s_cyc_o, 32'd0);
        check("responses after reset", m_ack_o | m_rty_o | m_err_o, 32'd0);
        $display("reset: %s", (errors == 0) ? "ok" : "failed");
        // each row starts from the grant that the row before it left behind.
        // halt, req, sel, kind, and mask, or mask, count, order, slave.
        add_row(1'b0, 4'b1111, 3'b100, 2'd0, 30'h0fff_ff00, 30'h1000_0000, 3'd4, 8'he4, 2'd3);
        add_row(1'b0, 4'b0100, 3'b010, 2'd0, 30'h3fff_ffff, 30'h0000_0000, 3'd1, 8'h02, 2'd2);
        add_row(1'b0, 4'b1010, 3'b000, 2'd1, 30'h3fff_ffff, 30'h2000_0000, 3'd2, 8'h07, 2'd0);
        add_row(1'b0, 4'b0001, 3'b000, 2'd2, 30'h0000_ffff, 30'h0000_0000, 3'd1, 8'h00, 2'd0);
        add_row(1'b0, 4'b1110, 3'b101, 2'd0, 30'h3fff_fff0, 30'h0000_0003, 3'd3, 8'h39, 2'd1);
        add_row(1'b1, 4'b0010, 3'b001, 2'd0, 30'h3fff_ffff, 30'h0000_0000, 3'd1, 8'h01, 2'd1);
        for (int i = 0; i < rows.size() && !timed_out; i++) begin
            apply_row(i, rows[i]);
        end
        $display("rows %0d, failed %0d, errors %0d", rows.size(), failed_rows, errors);
        if (errors == 0 && !timed_out) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* filelist.f */
+incdir+hdl
hdl/syscon_pkg.sv
hdl/wb_bus_if.sv
hdl/grant_arbiter.sv
hdl/master_mux.sv
hdl/slave_router.sv
hdl/wb_syscon.sv
tb/wb_syscon_assertions.sv
tb/tb_wb_syscon.sv
